// File: rtl/todPkg.sv
package todPkg;

    ////////////////////
    // Field widths
    ////////////////////

    localparam int SecondsWidth = 32;
    localparam int FractionWidth = 32;
    localparam int TimestampWidth = SecondsWidth + FractionWidth;

    // Extra low bits keep the rounding error of the increment small
    localparam int FractionWiden = 12;
    localparam int AccumulatorWidth = FractionWidth + FractionWiden;

    // Filter time constant is 2**FilterL2Alpha seconds
    localparam int FilterL2Alpha = 4;

    localparam int StatusCounterWidth = 10;

    ////////////////////
    // Enums
    ////////////////////

    typedef enum logic [1:0] {
        EvNone,
        EvShiftZero,
        EvShiftOne,
        EvSecondsMarker
    } eventKindT;

    typedef enum logic [1:0] {
        DivIdle,
        DivRun,
        DivLoad
    } dividerStateT;

    ////////////////////
    // Block to block words
    ////////////////////

    typedef struct packed {
        eventKindT kind;
    } todEventT;

    typedef struct packed {
        logic [FractionWidth-1:0] value;
        logic                     overflow;
    } fractionT;

    typedef struct packed {
        logic [SecondsWidth-1:0] value;
        logic                    secondsValid;
    } secondsT;

    typedef struct packed {
        logic [StatusCounterWidth-1:0] tooManyBits;
        logic [StatusCounterWidth-1:0] tooFewBits;
        logic [StatusCounterWidth-1:0] outOfSeq;
    } statusCountsT;

endpackage

// File: rtl/eventDecoder.sv
`timescale 1ns/1ps

module eventDecoder #(
    parameter logic [7:0] EvCodeShiftZero     = 8'h70,
    parameter logic [7:0] EvCodeShiftOne      = 8'h71,
    parameter logic [7:0] EvCodeSecondsMarker = 8'h7D
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       evCode,
    input  logic             evCodeValid,
    output todPkg::todEventT ev
);
    import todPkg::*;

    eventKindT kindNext;

    // Idle cycles and codes we do not care about both map to EvNone
    always_comb begin
        kindNext = EvNone;
        if (evCodeValid) begin
            case (evCode)
                EvCodeShiftZero:     kindNext = EvShiftZero;
                EvCodeShiftOne:      kindNext = EvShiftOne;
                EvCodeSecondsMarker: kindNext = EvSecondsMarker;
                default:             kindNext = EvNone;
            endcase
        end
    end

    // One cycle of latency, every downstream block sees the same event
    always_ff @(posedge clk) begin
        if (rst) begin
            ev <= '{kind: EvNone};
        end else begin
            ev <= '{kind: kindNext};
        end
    end

    // No stale event may leak out of reset into the counters downstream
    assert property (@(posedge clk) rst |=> ev.kind == EvNone);

endmodule

// File: rtl/ppsRateTracker.sv
`timescale 1ns/1ps

module ppsRateTracker #(
    parameter int NominalClkRate = 125_000_000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  todPkg::todEventT                    ev,
    output logic [todPkg::AccumulatorWidth-1:0] fractionIncrement,
    output logic                                ppsValid
);
    import todPkg::*;

    // Accepted marker spacing, 99 to 101 percent of nominal
    localparam int PpsEarly = NominalClkRate / 100 * 99;
    localparam int PpsLate = NominalClkRate / 100 * 101;
    localparam int PpsWindowLen = PpsLate - PpsEarly + 1;

    localparam int ClkCounterWidth = $clog2(PpsLate + 1);
    localparam int InitialWidth = $clog2(PpsEarly + 1) + 1;
    localparam int WindowWidth = $clog2(PpsWindowLen + 1) + 1;
    localparam int FilterWidth = ClkCounterWidth + FilterL2Alpha;
    localparam int DivCountWidth = $clog2(AccumulatorWidth + 1);

    localparam logic [FilterWidth-1:0] FilterReset =
        FilterWidth'(64'(NominalClkRate) << FilterL2Alpha);
    localparam logic [AccumulatorWidth-1:0] IncrementReset =
        AccumulatorWidth'((64'd1 << AccumulatorWidth) / 64'(NominalClkRate));

    logic                       isMarker;
    logic [ClkCounterWidth-1:0] clockCounter;
    logic [InitialWidth-1:0]    ppsInitial;
    logic [WindowWidth-1:0]     ppsWindow;
    logic                       initialDone;
    logic                       windowDone;
    logic                       inWindow;
    logic [2:0]                 validCount;

    logic [FilterWidth-1:0]      filterAcc;
    logic [ClkCounterWidth-1:0]  filteredRate;
    logic                        divStart;
    dividerStateT                divState;
    logic [DivCountWidth-1:0]    divBitsLeft;
    logic [ClkCounterWidth:0]    remainder;
    logic [ClkCounterWidth:0]    shiftedRem;
    logic [AccumulatorWidth-1:0] quotient;
    logic                        remFits;

    assign isMarker = ev.kind == EvSecondsMarker;

    // Down-counters go negative when done, so the sign bit is the flag
    assign initialDone = ppsInitial[InitialWidth-1];
    assign windowDone = ppsWindow[WindowWidth-1];
    assign inWindow = isMarker && initialDone && !windowDone;
    assign ppsValid = validCount[2];

    ////////////////////
    // Marker spacing
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            clockCounter <= '0;
            ppsInitial <= '0;
            ppsWindow <= '0;
            validCount <= '0;
        end else if (isMarker) begin
            clockCounter <= ClkCounterWidth'(1);
            ppsInitial <= InitialWidth'(PpsEarly - 2);
            ppsWindow <= WindowWidth'(PpsWindowLen - 1);
            if (!inWindow) begin
                validCount <= '0;
            end else if (!ppsValid) begin
                validCount <= validCount + 3'd1;
            end
        end else begin
            clockCounter <= clockCounter + 1'b1;
            if (!initialDone) begin
                ppsInitial <= ppsInitial - 1'b1;
            end else if (!windowDone) begin
                ppsWindow <= ppsWindow - 1'b1;
            end else begin
                // Window closed without a marker
                validCount <= '0;
            end
        end
    end

    // First-order low-pass, acc holds 2**FilterL2Alpha times the rate
    always_ff @(posedge clk) begin
        if (rst) begin
            filterAcc <= FilterReset;
            divStart <= 1'b0;
        end else begin
            divStart <= inWindow;
            if (inWindow) begin
                filterAcc <= filterAcc - (filterAcc >> FilterL2Alpha)
                           + FilterWidth'(clockCounter);
            end
        end
    end

    assign filteredRate = filterAcc[FilterWidth-1 -: ClkCounterWidth];

    ////////////////////
    // Increment divider
    ////////////////////

    // Restoring division of 2**AccumulatorWidth by the filtered rate
    assign shiftedRem = {remainder[ClkCounterWidth-1:0], 1'b0};
    assign remFits = shiftedRem >= {1'b0, filteredRate};

    always_ff @(posedge clk) begin
        if (rst) begin
            divState <= DivIdle;
            fractionIncrement <= IncrementReset;
        end else begin
            case (divState)
                DivIdle: begin
                    if (divStart) begin
                        divState <= DivRun;
                    end
                end
                DivRun: begin
                    if (divBitsLeft == DivCountWidth'(1)) begin
                        divState <= DivLoad;
                    end
                end
                DivLoad: begin
                    fractionIncrement <= quotient;
                    divState <= divStart ? DivRun : DivIdle;
                end
                default: divState <= DivIdle;
            endcase
        end
    end

    // Leading numerator bit is already in the remainder
    always_ff @(posedge clk) begin
        if (divState != DivRun) begin
            remainder <= (ClkCounterWidth + 1)'(1);
            quotient <= '0;
            divBitsLeft <= DivCountWidth'(AccumulatorWidth);
        end else begin
            remainder <= remFits ? shiftedRem - {1'b0, filteredRate} : shiftedRem;
            quotient <= {quotient[AccumulatorWidth-2:0], remFits};
            divBitsLeft <= divBitsLeft - 1'b1;
        end
    end

    // Starts are a full second apart, far longer than one division
    assert property (@(posedge clk) disable iff (rst) divStart |-> divState != DivRun);

endmodule

// File: rtl/fractionAccumulator.sv
`timescale 1ns/1ps

module fractionAccumulator (
    input  logic                                clk,
    input  logic                                rst,
    input  todPkg::todEventT                    ev,
    input  logic [todPkg::AccumulatorWidth-1:0] fractionIncrement,
    output todPkg::fractionT                    frac
);
    import todPkg::*;

    logic [AccumulatorWidth-1:0] fracAcc;
    logic [AccumulatorWidth:0]   fracSum;
    logic                        overflowHeld;

    // Carry out of the widened sum means the second ran long
    assign fracSum = {1'b0, fracAcc} + {1'b0, fractionIncrement};

    always_ff @(posedge clk) begin
        if (rst) begin
            fracAcc <= '0;
            overflowHeld <= 1'b0;
        end else if (ev.kind == EvSecondsMarker) begin
            fracAcc <= '0;
            overflowHeld <= 1'b0;
        end else if (overflowHeld || fracSum[AccumulatorWidth]) begin
            // Pin at just under one second until the marker shows up
            fracAcc <= '1;
            overflowHeld <= 1'b1;
        end else begin
            fracAcc <= fracSum[AccumulatorWidth-1:0];
        end
    end

    // Drop the widening bits on the way out
    assign frac = '{
        value:    fracAcc[AccumulatorWidth-1 -: FractionWidth],
        overflow: overflowHeld
    };

endmodule

// File: rtl/secondsReceiver.sv
`timescale 1ns/1ps

module secondsReceiver (
    input  logic                 clk,
    input  logic                 rst,
    input  todPkg::todEventT     ev,
    output todPkg::secondsT      secs,
    output todPkg::statusCountsT status
);
    import todPkg::*;

    localparam int BitsLeftWidth = $clog2(SecondsWidth + 1);

    logic                          isMarker;
    logic                          isShift;
    logic [SecondsWidth-1:0]       shiftReg;
    logic [BitsLeftWidth-1:0]      bitsLeft;
    logic                          tooManyFlag;
    logic                          exactBits;
    logic [SecondsWidth-1:0]       seconds;
    logic [SecondsWidth-1:0]       expectSeconds;
    logic                          secondsValid;
    logic [StatusCounterWidth-1:0] tooManyCnt;
    logic [StatusCounterWidth-1:0] tooFewCnt;
    logic [StatusCounterWidth-1:0] outOfSeqCnt;

    assign isMarker = ev.kind == EvSecondsMarker;
    assign isShift = (ev.kind == EvShiftZero) || (ev.kind == EvShiftOne);
    assign exactBits = (bitsLeft == '0) && !tooManyFlag;

    ////////////////////
    // Bit collection
    ////////////////////

    // MSB arrives first
    always_ff @(posedge clk) begin
        if (isShift) begin
            shiftReg <= {shiftReg[SecondsWidth-2:0], ev.kind == EvShiftOne};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || isMarker) begin
            bitsLeft <= BitsLeftWidth'(SecondsWidth);
            tooManyFlag <= 1'b0;
        end else if (isShift) begin
            if (bitsLeft == '0) begin
                tooManyFlag <= 1'b1;
            end else begin
                bitsLeft <= bitsLeft - 1'b1;
            end
        end
    end

    ////////////////////
    // Seconds on marker
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seconds <= '0;
            expectSeconds <= '0;
            secondsValid <= 1'b0;
            tooManyCnt <= '0;
            tooFewCnt <= '0;
            outOfSeqCnt <= '0;
        end else if (isMarker) begin
            if (exactBits) begin
                expectSeconds <= shiftReg + 1'b1;
                if (shiftReg == expectSeconds) begin
                    seconds <= shiftReg;
                    secondsValid <= 1'b1;
                end else begin
                    outOfSeqCnt <= outOfSeqCnt + 1'b1;
                    if (secondsValid) begin
                        seconds <= seconds + 1'b1;
                    end
                end
            end else begin
                if (tooManyFlag) begin
                    tooManyCnt <= tooManyCnt + 1'b1;
                end else begin
                    tooFewCnt <= tooFewCnt + 1'b1;
                end
                // Flywheel over the damaged second
                if (secondsValid) begin
                    seconds <= seconds + 1'b1;
                end
            end
        end
    end

    assign secs = '{value: seconds, secondsValid: secondsValid};
    assign status = '{tooManyBits: tooManyCnt, tooFewBits: tooFewCnt, outOfSeq: outOfSeqCnt};

    // Shift register holds still while a marker decides the second
    assert property (@(posedge clk) disable iff (rst)
        isMarker |=> shiftReg === $past(shiftReg));

endmodule

// File: rtl/todAssembler.sv
`timescale 1ns/1ps

module todAssembler (
    input  logic                              clk,
    input  logic                              rst,
    input  todPkg::secondsT                   secs,
    input  todPkg::fractionT                  frac,
    input  logic                              ppsValid,
    output logic [todPkg::TimestampWidth-1:0] timestampHA,
    output logic                              timestampHAValid,
    output logic [todPkg::TimestampWidth-1:0] timestamp,
    output logic                              timestampValid
);
    import todPkg::*;

    logic [FractionWidth-1:0] ticks;
    logic [FractionWidth-1:0] tickNow;
    logic                     fracRestart;
    logic                     tickSaturated;
    logic                     stampValid;

    // Fraction reads zero right after a marker has cleared it
    assign fracRestart = (frac.value == '0) && !frac.overflow;

    // Tick field lines up with the fraction restart on the same cycle
    assign tickNow = fracRestart ? '0 : ticks;
    assign tickSaturated = tickNow[FractionWidth-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            ticks <= '0;
        end else if (!tickSaturated) begin
            ticks <= tickNow + 1'b1;
        end
    end

    ////////////////////
    // Timestamps
    ////////////////////

    assign timestampHA = {secs.value, frac.value};
    assign timestamp = {secs.value, tickNow};

    // Any one of these makes the time of day untrustworthy
    assign stampValid = secs.secondsValid && ppsValid && !frac.overflow && !tickSaturated;

    assign timestampHAValid = stampValid;
    assign timestampValid = stampValid;

endmodule

// File: rtl/todReceiver.sv
`timescale 1ns/1ps

module todReceiver #(
    parameter int         NominalClkRate      = 125_000_000,
    parameter logic [7:0] EvCodeShiftZero     = 8'h70,
    parameter logic [7:0] EvCodeShiftOne      = 8'h71,
    parameter logic [7:0] EvCodeSecondsMarker = 8'h7D
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [7:0]                        evCode,
    input  logic                              evCodeValid,
    output logic [todPkg::TimestampWidth-1:0] timestampHA,
    output logic                              timestampHAValid,
    output logic [todPkg::TimestampWidth-1:0] timestamp,
    output logic                              timestampValid,
    output todPkg::statusCountsT              status
);
    import todPkg::*;

    todEventT                    ev;
    logic [AccumulatorWidth-1:0] fractionIncrement;
    logic                        ppsValid;
    fractionT                    frac;
    secondsT                     secs;

    eventDecoder #(
        .EvCodeShiftZero     (EvCodeShiftZero),
        .EvCodeShiftOne      (EvCodeShiftOne),
        .EvCodeSecondsMarker (EvCodeSecondsMarker)
    ) eventDecoder_i (
        .clk         (clk),
        .rst         (rst),
        .evCode      (evCode),
        .evCodeValid (evCodeValid),
        .ev          (ev)
    );

    // Fraction path
    ppsRateTracker #(
        .NominalClkRate (NominalClkRate)
    ) ppsRateTracker_i (
        .clk               (clk),
        .rst               (rst),
        .ev                (ev),
        .fractionIncrement (fractionIncrement),
        .ppsValid          (ppsValid)
    );

    fractionAccumulator fractionAccumulator_i (
        .clk               (clk),
        .rst               (rst),
        .ev                (ev),
        .fractionIncrement (fractionIncrement),
        .frac              (frac)
    );

    // Seconds path
    secondsReceiver secondsReceiver_i (
        .clk    (clk),
        .rst    (rst),
        .ev     (ev),
        .secs   (secs),
        .status (status)
    );

    todAssembler todAssembler_i (
        .clk              (clk),
        .rst              (rst),
        .secs             (secs),
        .frac             (frac),
        .ppsValid         (ppsValid),
        .timestampHA      (timestampHA),
        .timestampHAValid (timestampHAValid),
        .timestamp        (timestamp),
        .timestampValid   (timestampValid)
    );

endmodule

// File: bench/todReceiverTb.sv
`timescale 1ns/1ps

module todReceiverTb;
    import todPkg::*;

    localparam int NominalClkRate = 1000;
    localparam logic [7:0] CodeShiftZero = 8'h70;
    localparam logic [7:0] CodeShiftOne = 8'h71;
    localparam logic [7:0] CodeMarker = 8'h7D;
    // A valid code that none of the receivers react to
    localparam logic [7:0] CodeFiller = 8'hBC;

    localparam int MaxCycles = 16384;
    localparam int StimWords = 1024;
    localparam int RecordWords = 8;
    localparam int TailCycles = 110;
    localparam int ResetCycles = 16;

    // Fraction step at nominal rate is floor(2**44 / rate)
    localparam logic [63:0] NominalIncrement = (64'd1 << 44) / 64'(NominalClkRate);

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } driveT;

    typedef struct packed {
        logic [31:0]                   cycle;
        logic [31:0]                   offset;
        logic [31:0]                   seconds;
        logic                          valid;
        logic [StatusCounterWidth-1:0] tooManyBits;
        logic [StatusCounterWidth-1:0] tooFewBits;
        logic [StatusCounterWidth-1:0] outOfSeq;
    } checkPointT;

    logic                      clk;
    logic                      rst;
    logic [7:0]                evCode;
    logic                      evCodeValid;
    logic [TimestampWidth-1:0] timestampHA;
    logic                      timestampHAValid;
    logic [TimestampWidth-1:0] timestamp;
    logic                      timestampValid;
    statusCountsT              status;

    logic [31:0] stimMem [StimWords];
    driveT       schedule [MaxCycles];
    logic        shiftSlot [MaxCycles];
    checkPointT  checkQueue [$];
    logic [31:0] lfsrState;

    int valueErrors = 0;
    int otherErrors = 0;
    int checksRun = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int totalSpacing = 0;
    int runLength = 0;

    todReceiver #(
        .NominalClkRate      (NominalClkRate),
        .EvCodeShiftZero     (CodeShiftZero),
        .EvCodeShiftOne      (CodeShiftOne),
        .EvCodeSecondsMarker (CodeMarker)
    ) todReceiver_i (
        .clk              (clk),
        .rst              (rst),
        .evCode           (evCode),
        .evCodeValid      (evCodeValid),
        .timestampHA      (timestampHA),
        .timestampHAValid (timestampHAValid),
        .timestamp        (timestamp),
        .timestampValid   (timestampValid),
        .status           (status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] result;
        logic        feedback;
        result = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            result = {result[30:0], feedback};
        end
        return result;
    endfunction

    // Shift events land MSB first at random cycles of the gap and the marker closes it
    task automatic buildSecond(input int prevMarker, input int spacing, input int bitCount,
                               input logic [31:0] value);
        int          gap;
        int          pos;
        int          bitIdx;
        logic [63:0] wide;
        logic [7:0]  idleCode;
        gap = spacing - 1;
        wide = {32'h0, value};
        for (int k = 0; k < bitCount; k++) begin
            pos = int'(randomBits(10)) % gap;
            while (shiftSlot[prevMarker + 1 + pos]) begin
                pos = (pos + 1) % gap;
            end
            shiftSlot[prevMarker + 1 + pos] = 1'b1;
        end
        bitIdx = bitCount - 1;
        for (int s = prevMarker + 1; s < prevMarker + spacing; s++) begin
            if (shiftSlot[s]) begin
                schedule[s] = '{valid: 1'b1, code: wide[bitIdx] ? CodeShiftOne : CodeShiftZero};
                bitIdx--;
            end else if (randomBits(1) != 0) begin
                schedule[s] = '{valid: 1'b1, code: CodeFiller};
            end else begin
                // Strobe low over codes that would act if it were ignored
                idleCode = (randomBits(1) != 0) ? CodeMarker : CodeShiftOne;
                schedule[s] = '{valid: 1'b0, code: idleCode};
            end
        end
        schedule[prevMarker + spacing] = '{valid: 1'b1, code: CodeMarker};
    endtask

    task automatic loadStimulus();
        int          word;
        int          markerCycle;
        int          spacing;
        logic [31:0] kind;
        logic        fits;
        checkPointT  cp;
        for (int i = 0; i < StimWords; i++) begin
            stimMem[i] = '0;
        end
        for (int i = 0; i < MaxCycles; i++) begin
            schedule[i] = '{valid: 1'b0, code: 8'h00};
            shiftSlot[i] = 1'b0;
        end
        $readmemh("bench/todStim.txt", stimMem);
        word = 0;
        markerCycle = 0;
        while (word + RecordWords <= StimWords && stimMem[word] != 0) begin
            kind = stimMem[word];
            assert (kind == 1 || kind == 2) else begin
                otherErrors++;
                $display("Unknown record kind %0d in the stimulus file at word %0d",
                         kind, word);
            end
            if (kind == 1) begin
                spacing = int'(stimMem[word + 3]);
                fits = (markerCycle + spacing + TailCycles <= MaxCycles)
                    && (int'(stimMem[word + 2]) < spacing);
                assert (fits) else begin
                    otherErrors++;
                    $display("Second record at word %0d does not fit its gap", word);
                end
                if (fits) begin
                    buildSecond(markerCycle, spacing, int'(stimMem[word + 2]),
                                stimMem[word + 1]);
                    markerCycle += spacing;
                end
            end else if (kind == 2) begin
                cp.cycle = markerCycle + stimMem[word + 1];
                cp.offset = stimMem[word + 1];
                cp.seconds = stimMem[word + 2];
                cp.valid = stimMem[word + 3][0];
                cp.tooManyBits = stimMem[word + 4][StatusCounterWidth-1:0];
                cp.tooFewBits = stimMem[word + 5][StatusCounterWidth-1:0];
                cp.outOfSeq = stimMem[word + 6][StatusCounterWidth-1:0];
                assert (cp.offset >= 2) else begin
                    otherErrors++;
                    $display("Check record at word %0d comes too soon after its marker", word);
                end
                checkQueue.push_back(cp);
            end
            word += RecordWords;
        end
        totalSpacing = markerCycle;
        runLength = markerCycle + TailCycles;
    endtask

    task automatic expectEqual(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual === expected) else begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    // Fraction is the top 32 bits of the 44 bit sum of (N - 2) steps
    task automatic verifyCheckPoint(input checkPointT cp);
        logic [63:0] fracSum;
        logic [31:0] ticksExpected;
        ticksExpected = cp.offset - 2;
        fracSum = 64'(ticksExpected) * NominalIncrement;
        checksRun++;
        expectEqual("timestampHA[63:32]", timestampHA[63:32], cp.seconds);
        expectEqual("timestampHA[31:0]", timestampHA[31:0], fracSum[43:12]);
        expectEqual("timestamp[63:32]", timestamp[63:32], cp.seconds);
        expectEqual("timestamp[31:0]", timestamp[31:0], ticksExpected);
        expectEqual("timestampHAValid", timestampHAValid, cp.valid);
        expectEqual("timestampValid", timestampValid, cp.valid);
        expectEqual("status.tooManyBits", status.tooManyBits, cp.tooManyBits);
        expectEqual("status.tooFewBits", status.tooFewBits, cp.tooFewBits);
        expectEqual("status.outOfSeq", status.outOfSeq, cp.outOfSeq);
    endtask

    ////////////////////
    // Run
    ////////////////////

    initial begin : watchdog
        wait (cycleLimit != 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the stimulus never finished", cycleCount);
        $display("Verification failed");
        $finish;
    end

    initial begin : mainSequence
        int checkIdx;
        rst = 1'b1;
        evCode = 8'h00;
        evCodeValid = 1'b0;
        lfsrState = 32'h572a;
        checkIdx = 0;
        loadStimulus();
        cycleLimit = totalSpacing + 200;
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        // Outputs are sampled before the inputs change on each falling edge
        for (int c = 0; c < runLength; c++) begin
            @(negedge clk);
            while (checkIdx < checkQueue.size() && checkQueue[checkIdx].cycle == c) begin
                verifyCheckPoint(checkQueue[checkIdx]);
                checkIdx++;
            end
            evCodeValid = schedule[c].valid;
            evCode = schedule[c].code;
        end
        assert (checkIdx == checkQueue.size() && checksRun > 0) else begin
            otherErrors++;
            $display("Only %0d of %0d check points were reached",
                     checkIdx, checkQueue.size());
        end
        $display("Summary: %0d check points, %0d value errors, %0d other errors",
                 checksRun, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: bench/todStim.txt
// Second: 1 seconds bitCount spacing 0 0 0 0  (spacing = cycles since the previous marker)
// Check:  2 offset seconds valid tooManyBits tooFewBits outOfSeq 0  (offset from last marker)
// Lock-up, expected seconds starts at 0 so the first marker is out of sequence
1 6A1B2C00 20 3E8 0 0 0 0
2 2 00000000 0 0 0 1 0
2 1F4 00000000 0 0 0 1 0
1 6A1B2C01 20 3E8 0 0 0 0
2 2 6A1B2C01 0 0 0 1 0
1 6A1B2C02 20 3E8 0 0 0 0
2 2 6A1B2C02 0 0 0 1 0
1 6A1B2C03 20 3E8 0 0 0 0
2 2 6A1B2C03 0 0 0 1 0
2 3E6 6A1B2C03 0 0 0 1 0
// Fourth in-window marker, valids come up
1 6A1B2C04 20 3E8 0 0 0 0
2 2 6A1B2C04 1 0 0 1 0
2 3 6A1B2C04 1 0 0 1 0
2 309 6A1B2C04 1 0 0 1 0
2 3E7 6A1B2C04 1 0 0 1 0
// 31 bits, then a good second that no longer matches expected
1 6A1B2C05 1F 3E8 0 0 0 0
2 2 6A1B2C05 1 0 1 1 0
2 100 6A1B2C05 1 0 1 1 0
1 6A1B2C06 20 3E8 0 0 0 0
2 2 6A1B2C06 1 0 1 2 0
// 33 bits
1 6A1B2C07 21 3E8 0 0 0 0
2 2 6A1B2C07 1 1 1 2 0
1 6A1B2C08 20 3E8 0 0 0 0
2 2 6A1B2C08 1 1 1 3 0
// 6A1B2C09 skipped, seconds flywheels
1 6A1B2C0A 20 3E8 0 0 0 0
2 2 6A1B2C09 1 1 1 4 0
2 2BC 6A1B2C09 1 1 1 4 0
1 6A1B2C0B 20 3E8 0 0 0 0
2 2 6A1B2C0B 1 1 1 4 0
// Early marker at 950 cycles drops the valids
1 6A1B2C0C 20 3B6 0 0 0 0
2 2 6A1B2C0C 0 1 1 4 0
2 384 6A1B2C0C 0 1 1 4 0
1 6A1B2C0D 20 3E8 0 0 0 0
2 2 6A1B2C0D 0 1 1 4 0
1 6A1B2C0E 20 3E8 0 0 0 0
2 2 6A1B2C0E 0 1 1 4 0
1 6A1B2C0F 20 3E8 0 0 0 0
2 2 6A1B2C0F 0 1 1 4 0
// Relocked after four in-window markers
1 6A1B2C10 20 3E8 0 0 0 0
2 2 6A1B2C10 1 1 1 4 0
2 64 6A1B2C10 1 1 1 4 0
0 0 0 0 0 0 0 0

// File: tb.f
rtl/todPkg.sv
rtl/eventDecoder.sv
rtl/ppsRateTracker.sv
rtl/fractionAccumulator.sv
rtl/secondsReceiver.sv
rtl/todAssembler.sv
rtl/todReceiver.sv
bench/todReceiverTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run from the project root, judge the run by its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module todReceiverTb \
    -f tb.f -o todReceiverSim \
    && ./obj_dir/todReceiverSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log \
    && echo "Simulation run OK" && exit 0 \
    || { echo "Simulation run FAILED, see sim.log"; exit 1; }
